/* run.sh */
#!/usr/bin/env bash
# build and run the packet aligner testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module pkt_sync_tb -o pkt_sync_sim

out=$(./obj_dir/pkt_sync_sim)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
   exit 0
fi
exit 1

/* src/axis_if.sv */
/*
 * valid/ready stream interface.
 * carries one payload per transfer; a transfer happens on every
 * cycle with valid and ready both high. the sender holds valid
 * and payload until the transfer and never waits on ready.
 */
interface axis_if
   import axis_pkg::*;
#(
   parameter type payload_t = stream_word_t
) ();

   logic     valid;
   logic     ready;
   payload_t payload;

   // sending side.
   modport tx (
      output valid,
      output payload,
      input  ready
   );

   // receiving side.
   modport rx (
      input  valid,
      input  payload,
      output ready
   );

endinterface

/* src/axis_pkg.sv */
/*
 * stream word types.
 * one word of a valid/ready packet stream: data, byte keep,
 * end-of-packet marker and a user field for metadata.
 */
`include "pkt_sync_config.svh"

package axis_pkg;

   typedef logic [`PS_DATA_BYTES*8-1:0] data_t;
   typedef logic [`PS_DATA_BYTES-1:0]   keep_t;

   // sized to hold the synchronizer metadata.
   typedef logic [`PS_PID_WID-1:0]      user_t;

   typedef struct packed {
      data_t data;
      keep_t keep;
      logic  last;
      user_t user;
   } stream_word_t;

endpackage

/* src/pkt_sync_config.svh */
/*
 * packet aligner configuration.
 * build-time sizes for the stream word, the packet id,
 * the ingress buffers and the mismatch statistics.
 */
`ifndef PKT_SYNC_CONFIG_SVH
`define PKT_SYNC_CONFIG_SVH

// bytes carried by one data word.
`define PS_DATA_BYTES 4

// packet id carried in the user field of every word.
`define PS_PID_WID 8

// entries per ingress FIFO, a power of two.
`define PS_FIFO_DEPTH 4

// width of the saturating mismatch counter.
`define PS_CNT_WID 8

`endif

/* src/pkt_sync_top.sv */
/*
 * two-stream packet aligner.
 * each ingress stream goes through its own elastic FIFO, then the
 * synchronizer lines up packet starts across both streams and
 * checks that their packet ids agree.
 */
`include "pkt_sync_config.svh"

module pkt_sync_top
   import axis_pkg::*;
   import sync_pkg::*;
(
   input  logic                   clk,
   input  logic                   srst,

   input  logic                   in0_valid,
   output logic                   in0_ready,
   input  data_t                  in0_data,
   input  keep_t                  in0_keep,
   input  logic                   in0_last,
   input  logic [`PS_PID_WID-1:0] in0_pid,

   input  logic                   in1_valid,
   output logic                   in1_ready,
   input  data_t                  in1_data,
   input  keep_t                  in1_keep,
   input  logic                   in1_last,
   input  logic [`PS_PID_WID-1:0] in1_pid,

   output logic                   out0_valid,
   input  logic                   out0_ready,
   output data_t                  out0_data,
   output keep_t                  out0_keep,
   output logic                   out0_last,
   output logic [`PS_PID_WID-1:0] out0_pid,

   output logic                   out1_valid,
   input  logic                   out1_ready,
   output data_t                  out1_data,
   output keep_t                  out1_keep,
   output logic                   out1_last,
   output logic [`PS_PID_WID-1:0] out1_pid,

   output logic                   sop_mismatch,
   output mismatch_cnt_t          mismatch_count
);

   axis_if #(.payload_t(stream_word_t)) fifo0_in ();
   axis_if #(.payload_t(stream_word_t)) fifo1_in ();
   axis_if #(.payload_t(stream_word_t)) sync_in0 ();
   axis_if #(.payload_t(stream_word_t)) sync_in1 ();
   axis_if #(.payload_t(stream_word_t)) out0 ();
   axis_if #(.payload_t(stream_word_t)) out1 ();

   sync_meta_t in0_meta;
   sync_meta_t in1_meta;
   sync_meta_t out0_meta;
   sync_meta_t out1_meta;

   // ------------------------------------------------------------------
   // ingress packing, pid travels in the user field
   // ------------------------------------------------------------------
   assign in0_meta.pid     = in0_pid;
   assign fifo0_in.valid   = in0_valid;
   assign fifo0_in.payload = '{data: in0_data, keep: in0_keep, last: in0_last, user: in0_meta};
   assign in0_ready        = fifo0_in.ready;

   assign in1_meta.pid     = in1_pid;
   assign fifo1_in.valid   = in1_valid;
   assign fifo1_in.payload = '{data: in1_data, keep: in1_keep, last: in1_last, user: in1_meta};
   assign in1_ready        = fifo1_in.ready;

   // ------------------------------------------------------------------
   // datapath
   // ------------------------------------------------------------------
   stream_fifo #(.payload_t(stream_word_t), .DEPTH(`PS_FIFO_DEPTH)) u_fifo0 (
      .clk  (clk),
      .srst (srst),
      .in   (fifo0_in),
      .out  (sync_in0)
   );

   stream_fifo #(.payload_t(stream_word_t), .DEPTH(`PS_FIFO_DEPTH)) u_fifo1 (
      .clk  (clk),
      .srst (srst),
      .in   (fifo1_in),
      .out  (sync_in1)
   );

   stream_sync u_sync (
      .clk            (clk),
      .srst           (srst),
      .in0            (sync_in0),
      .in1            (sync_in1),
      .out0           (out0),
      .out1           (out1),
      .sop_mismatch   (sop_mismatch),
      .mismatch_count (mismatch_count)
   );

   // ------------------------------------------------------------------
   // egress unpacking
   // ------------------------------------------------------------------
   assign out0.ready = out0_ready;
   assign out0_valid = out0.valid;
   assign out0_data  = out0.payload.data;
   assign out0_keep  = out0.payload.keep;
   assign out0_last  = out0.payload.last;
   assign out0_meta  = out0.payload.user;
   assign out0_pid   = out0_meta.pid;

   assign out1.ready = out1_ready;
   assign out1_valid = out1.valid;
   assign out1_data  = out1.payload.data;
   assign out1_keep  = out1.payload.keep;
   assign out1_last  = out1.payload.last;
   assign out1_meta  = out1.payload.user;
   assign out1_pid   = out1_meta.pid;

endmodule

/* src/stream_fifo.sv */
/*
 * stream FIFO.
 * synchronous circular buffer on one valid/ready stream. ingress
 * ready follows free space only; the head word is presented with
 * valid from the cycle after it was written.
 */
`include "pkt_sync_config.svh"

module stream_fifo
   import axis_pkg::*;
#(
   parameter type payload_t = stream_word_t,
   parameter int  DEPTH     = `PS_FIFO_DEPTH
) (
   input  logic clk,
   input  logic srst,

   axis_if.rx   in,
   axis_if.tx   out
);

   localparam int AWID = $clog2(DEPTH);

   payload_t      mem [DEPTH];

   // extra msb tells a full buffer from an empty one.
   logic [AWID:0] wr_ptr;
   logic [AWID:0] rd_ptr;

   logic          full;
   logic          empty;
   logic          push;
   logic          pop;

   // ------------------------------------------------------------------
   // status and handshake
   // ------------------------------------------------------------------
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AWID] != rd_ptr[AWID]) &&
                  (wr_ptr[AWID-1:0] == rd_ptr[AWID-1:0]);

   assign in.ready  = !full;
   assign push      = in.valid && !full;

   assign out.valid   = !empty;
   assign out.payload = mem[rd_ptr[AWID-1:0]];
   assign pop         = out.valid && out.ready;

   // ------------------------------------------------------------------
   // storage and pointers
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[AWID-1:0]] <= in.payload;
      end
   end

   always_ff @(posedge clk) begin
      if (srst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

/* src/stream_sync.sv */
/*
 * two-stream start-of-packet synchronizer.
 * holds whichever stream reaches a packet start first until the
 * other one does too, then releases both starts together when
 * their packet ids agree. an id disagreement stalls both streams
 * and is counted once. words inside a packet flow freely.
 */
module stream_sync
   import axis_pkg::*;
   import sync_pkg::*;
(
   input  logic          clk,
   input  logic          srst,

   axis_if.rx            in0,
   axis_if.rx            in1,
   axis_if.tx            out0,
   axis_if.tx            out1,

   output logic          sop_mismatch,
   output mismatch_cnt_t mismatch_count
);

   stream_word_t word0;
   stream_word_t word1;
   sync_meta_t   meta0;
   sync_meta_t   meta1;

   // index 0 and 1 follow the two streams.
   logic [1:0]   sop_q;
   logic [1:0]   xfer;
   logic [1:0]   xfer_last;

   logic         sync_sop;
   logic         match;
   logic         release0;
   logic         release1;
   logic         mismatch_q;

   assign word0 = in0.payload;
   assign word1 = in1.payload;
   assign meta0 = word0.user;
   assign meta1 = word1.user;

   // ------------------------------------------------------------------
   // start-of-packet tracking
   // ------------------------------------------------------------------
   assign xfer[0]      = in0.valid && in0.ready;
   assign xfer[1]      = in1.valid && in1.ready;
   assign xfer_last[0] = word0.last;
   assign xfer_last[1] = word1.last;

   // the next word is a packet start after a last word.
   always_ff @(posedge clk) begin
      if (srst) begin
         sop_q <= 2'b11;
      end else begin
         for (int i = 0; i < 2; i++) begin
            if (xfer[i]) begin
               sop_q[i] <= xfer_last[i];
            end
         end
      end
   end

   // ------------------------------------------------------------------
   // id compare and joint release
   // ------------------------------------------------------------------
   assign sync_sop     = sop_q[0] && in0.valid && sop_q[1] && in1.valid;
   assign match        = (meta0.pid == meta1.pid);
   assign sop_mismatch = sync_sop && !match;

   // a start word leaves only when its partner can leave with it.
   assign release0 = (sync_sop && match && out1.ready) || !sop_q[0];
   assign release1 = (sync_sop && match && out0.ready) || !sop_q[1];

   assign in0.ready    = out0.ready && release0;
   assign out0.valid   = in0.valid && release0;
   assign out0.payload = in0.payload;

   assign in1.ready    = out1.ready && release1;
   assign out1.valid   = in1.valid && release1;
   assign out1.payload = in1.payload;

   // ------------------------------------------------------------------
   // mismatch statistics
   // ------------------------------------------------------------------
   // count the rising edge only, stop at full scale.
   always_ff @(posedge clk) begin
      if (srst) begin
         mismatch_q     <= 1'b0;
         mismatch_count <= '0;
      end else begin
         mismatch_q <= sop_mismatch;
         if (sop_mismatch && !mismatch_q && (mismatch_count != '1)) begin
            mismatch_count <= mismatch_count + 1'b1;
         end
      end
   end

endmodule

/* src/sync_pkg.sv */
/*
 * synchronizer types.
 * per-packet metadata found in the stream user field, and the
 * mismatch statistics count.
 */
`include "pkt_sync_config.svh"

package sync_pkg;

   // only meaningful on start-of-packet words.
   typedef struct packed {
      logic [`PS_PID_WID-1:0] pid;
   } sync_meta_t;

   typedef logic [`PS_CNT_WID-1:0] mismatch_cnt_t;

endpackage

/* tests/pkt_sync_tb.sv */
/*
 * testbench for the two-stream packet aligner.
 * directed tests feed both ingress streams from word queues and
 * check egress order, aligned packet starts, back-pressure and
 * packet id mismatch handling.
 */
`include "pkt_sync_config.svh"

module pkt_sync_tb
   import axis_pkg::*;
   import sync_pkg::*;
();

   localparam int MAX_CYCLES = 3000;

   logic clk, srst;
   logic in0_valid, in0_ready, in0_last, in1_valid, in1_ready, in1_last;
   logic out0_valid, out0_ready, out0_last, out1_valid, out1_ready, out1_last;
   data_t in0_data, in1_data, out0_data, out1_data;
   keep_t in0_keep, in1_keep, out0_keep, out1_keep;
   logic [`PS_PID_WID-1:0] in0_pid, in1_pid, out0_pid, out1_pid;
   logic sop_mismatch;
   mismatch_cnt_t mismatch_count;

   stream_word_t src0_q[$], src1_q[$], exp0_q[$], exp1_q[$];
   int sop0_q[$], sop1_q[$];
   int cycle = 0;
   int errors = 0;
   int checks = 0;
   int acc0, acc1;
   integer seed;

   pkt_sync_top u_pkt_sync_top (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("** FAIL **");
         $finish;
      end
   end

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   task automatic check_val(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: %s expected %0h actual %0h", name, what, exp, act);
      end
   endtask

   task automatic apply_reset;
      srst = 1'b1;
      repeat (5) @(posedge clk);
      #2 srst = 1'b0;
   endtask

   // words carry stream, pid and index in the data so any slip shows up.
   task automatic add_packet(input int n, input int len, input logic [`PS_PID_WID-1:0] pid);
      stream_word_t w;
      for (int i = 0; i < len; i++) begin
         w.data = data_t'((n << 28) | (int'(pid) << 12) | i);
         w.keep = (i == len - 1) ? keep_t'(3) : '1;
         w.last = (i == len - 1);
         w.user = pid;
         if (n == 0) begin
            src0_q.push_back(w);
            exp0_q.push_back(w);
         end else begin
            src1_q.push_back(w);
            exp1_q.push_back(w);
         end
      end
   endtask

   task automatic drive_in(input int n, input logic v, input stream_word_t w);
      if (n == 0) begin
         in0_valid = v;
         in0_data  = w.data;
         in0_keep  = w.keep;
         in0_last  = w.last;
         in0_pid   = w.user;
      end else begin
         in1_valid = v;
         in1_data  = w.data;
         in1_keep  = w.keep;
         in1_last  = w.last;
         in1_pid   = w.user;
      end
   endtask

   function automatic stream_word_t out_word(input int n);
      stream_word_t w;
      if (n == 0) begin
         w = '{data: out0_data, keep: out0_keep, last: out0_last, user: out0_pid};
      end else begin
         w = '{data: out1_data, keep: out1_keep, last: out1_last, user: out1_pid};
      end
      return w;
   endfunction

   // source: hold each word until ready was seen, then move on.
   task automatic send_stream(input int n, input int gap);
      stream_word_t w;
      repeat (gap + 1) @(posedge clk);
      while ((n == 0) ? (src0_q.size() > 0) : (src1_q.size() > 0)) begin
         w = (n == 0) ? src0_q.pop_front() : src1_q.pop_front();
         #2 drive_in(n, 1'b1, w);
         @(negedge clk);
         while (((n == 0) ? in0_ready : in1_ready) !== 1'b1) @(negedge clk);
         if (n == 0) acc0++;
         else acc1++;
         @(posedge clk);
      end
      #2 drive_in(n, 1'b0, '0);
   endtask

   // sink: ready low for hold cycles, then always or randomly high.
   task automatic recv_stream(input int n, input int count, input int hold,
                              input bit rnd, input string name);
      stream_word_t act, exp;
      int got;
      bit sop, r;
      got = 0;
      sop = 1'b1;
      while (got < count) begin
         @(posedge clk);
         if (hold > 0) begin
            r = 1'b0;
            hold--;
         end else begin
            r = rnd ? (($random(seed) & 3) != 0) : 1'b1;
         end
         #2;
         if (n == 0) out0_ready = r;
         else out1_ready = r;
         @(negedge clk);
         if (r && ((n == 0) ? out0_valid : out1_valid)) begin
            act = out_word(n);
            if ((n == 0) ? (exp0_q.size() == 0) : (exp1_q.size() == 0)) begin
               errors++;
               $display("%s: stream %0d delivered a word that was never sent", name, n);
            end else begin
               exp = (n == 0) ? exp0_q.pop_front() : exp1_q.pop_front();
               checks++;
               if (act !== exp) begin
                  errors++;
                  $display("FAIL %s: stream %0d expected %h actual %h", name, n, exp, act);
               end
            end
            if (sop && n == 0) sop0_q.push_back(cycle);
            if (sop && n == 1) sop1_q.push_back(cycle);
            sop = act.last;
            got++;
         end
      end
   endtask

   task automatic check_alignment(input string name, input int pkts);
      check_val(name, "packet starts on stream 0", pkts, sop0_q.size());
      check_val(name, "packet starts on stream 1", pkts, sop1_q.size());
      while (sop0_q.size() > 0 && sop1_q.size() > 0) begin
         check_val(name, "start cycle of stream 1", sop0_q.pop_front(), sop1_q.pop_front());
      end
      sop0_q.delete();
      sop1_q.delete();
   endtask

   // ------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------
   task automatic reset_state;
      @(negedge clk);
      check_val("reset", "out0_valid", 0, out0_valid);
      check_val("reset", "out1_valid", 0, out1_valid);
      check_val("reset", "sop_mismatch", 0, sop_mismatch);
      check_val("reset", "mismatch_count", 0, mismatch_count);
      check_val("reset", "in0_ready", 1, in0_ready);
      check_val("reset", "in1_ready", 1, in1_ready);
   endtask

   task automatic aligned_start;
      add_packet(0, 3, 8'h11);
      add_packet(1, 5, 8'h11);
      fork
         send_stream(0, 0);
         send_stream(1, 6);
         recv_stream(0, 3, 0, 1'b0, "aligned");
         recv_stream(1, 5, 0, 1'b0, "aligned");
      join
      check_alignment("aligned", 1);
   endtask

   task automatic unequal_tails;
      add_packet(0, 2, 8'h21);
      add_packet(1, 4, 8'h21);
      add_packet(0, 5, 8'h22);
      add_packet(1, 1, 8'h22);
      add_packet(0, 3, 8'h23);
      add_packet(1, 3, 8'h23);
      fork
         send_stream(0, 0);
         send_stream(1, 0);
         recv_stream(0, 10, 0, 1'b0, "tails");
         recv_stream(1, 8, 0, 1'b0, "tails");
      join
      check_alignment("tails", 3);
   endtask

   task automatic egress_backpressure;
      acc0 = 0;
      acc1 = 0;
      add_packet(0, 6, 8'h31);
      add_packet(1, 6, 8'h31);
      add_packet(0, 3, 8'h32);
      add_packet(1, 2, 8'h32);
      fork
         send_stream(0, 0);
         send_stream(1, 0);
         recv_stream(0, 9, 12, 1'b1, "backpressure");
         recv_stream(1, 8, 0, 1'b1, "backpressure");
         begin
            repeat (10) @(posedge clk);
            @(negedge clk);
            check_val("backpressure", "in0_ready while held", 0, in0_ready);
            check_val("backpressure", "words buffered", `PS_FIFO_DEPTH, acc0);
         end
      join
      check_alignment("backpressure", 2);
   endtask

   task automatic pid_mismatch;
      bit seen;
      seen = 1'b0;
      add_packet(0, 2, 8'h41);
      add_packet(1, 2, 8'h42);
      @(posedge clk);
      #2;
      out0_ready = 1'b1;
      out1_ready = 1'b1;
      fork
         send_stream(0, 0);
         send_stream(1, 0);
      join
      for (int i = 0; i < 12; i++) begin
         @(negedge clk);
         if (sop_mismatch) seen = 1'b1;
         check_val("mismatch", "out0_valid", 0, out0_valid);
         check_val("mismatch", "out1_valid", 0, out1_valid);
      end
      if (!seen) begin
         errors++;
         $display("mismatch: sop_mismatch never went high for differing packet ids");
      end
      check_val("mismatch", "mismatch_count", 1, mismatch_count);
      @(posedge clk);
      #2;
      apply_reset;
      exp0_q.delete();
      exp1_q.delete();
      @(negedge clk);
      check_val("mismatch", "mismatch_count after reset", 0, mismatch_count);
   endtask

   initial begin
      seed = 92583;
      srst = 1'b1;
      out0_ready = 1'b0;
      out1_ready = 1'b0;
      drive_in(0, 1'b0, '0);
      drive_in(1, 1'b0, '0);
      apply_reset;
      reset_state;
      aligned_start;
      unequal_tails;
      egress_backpressure;
      pid_mismatch;
      $display("checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+src
src/axis_pkg.sv
src/sync_pkg.sv
src/axis_if.sv
src/stream_fifo.sv
src/stream_sync.sv
src/pkt_sync_top.sv
tests/pkt_sync_tb.sv
